//--- hw/llc_macros.svh
`ifndef LLC_MACROS_SVH
`define LLC_MACROS_SVH

// array geometry
`define LLC_NUM_WAYS 4
`define LLC_SET_BITS 6
`define LLC_BANK_BITS 1

// field widths
`define LLC_LINE_BITS 64
`define LLC_TAG_BITS 16
`define LLC_SHARERS_BITS 8

// apb register map
`define LLC_REG_SET 8'h00
`define LLC_REG_WAY 8'h04
`define LLC_REG_TAG 8'h08
`define LLC_REG_META 8'h0C
`define LLC_REG_LINE_LO 8'h10
`define LLC_REG_LINE_HI 8'h14
`define LLC_REG_CMD 8'h18

`endif

//--- hw/llc_pkg.sv
`include "llc_macros.svh"

package llc_pkg;

    typedef logic [`LLC_SET_BITS-1:0] llc_set_t;
    typedef logic [$clog2(`LLC_NUM_WAYS)-1:0] llc_way_t;
    typedef logic [`LLC_TAG_BITS-1:0] llc_tag_t;
    typedef logic [`LLC_LINE_BITS-1:0] line_t;
    typedef logic [2:0] owner_t;
    typedef logic [`LLC_SHARERS_BITS-1:0] sharers_t;
    typedef logic hprot_t;

    typedef enum logic [2:0] {
        invalid = 3'd0,
        valid = 3'd1,
        shared = 3'd2,
        exclusive = 3'd3,
        modified = 3'd4
    } llc_state_t;

    typedef struct packed {
        llc_tag_t tag;
        llc_state_t state;
        owner_t owner;
        sharers_t sharers;
        hprot_t hprot;
        logic dirty;
        llc_way_t evict_way;
    } llc_meta_t;

    // meta sits above the line
    typedef struct packed {
        llc_meta_t meta;
        line_t line;
    } llc_entry_t;

endpackage

//--- hw/llc_mem_if.sv
`timescale 1ns/1ps
`include "llc_macros.svh"

interface llc_mem_if;

    logic rd_en;
    llc_pkg::llc_set_t rd_set;

    logic wr_en;
    llc_pkg::llc_set_t wr_set;
    llc_pkg::llc_way_t wr_way;
    llc_pkg::llc_entry_t wr_entry;

    // every way of the set, one cycle after rd_en
    llc_pkg::llc_entry_t rd_entry [`LLC_NUM_WAYS];

    modport ctrl (
        output rd_en, rd_set, wr_en, wr_set, wr_way, wr_entry,
        input rd_entry
    );

    modport mem (
        input rd_en, rd_set, wr_en, wr_set, wr_way, wr_entry,
        output rd_entry
    );

endinterface

//--- hw/dp_bram.sv
`timescale 1ns/1ps

module dp_bram #(
    parameter type payload_t = logic [31:0],
    parameter int DEPTH = 64
) (
    input logic clk,
    input logic [$clog2(DEPTH)-1:0] addr_a,
    input logic [$clog2(DEPTH)-1:0] addr_b,
    input logic we_a,
    input logic we_b,
    input logic en,
    input payload_t d,
    output payload_t q_a,
    output payload_t q_b
);

    payload_t ram [DEPTH];

    always_ff @(posedge clk) begin
        if (we_a) begin
            ram[addr_a] <= d;
        end
        if (we_b) begin
            ram[addr_b] <= d;
        end
        // registered read on both ports
        if (en) begin
            q_a <= ram[addr_a];
            q_b <= ram[addr_b];
        end
    end

    // shared write datum, so only one port may take it
    a_one_writer: assert property (@(posedge clk) !(we_a && we_b))
        else $error("dp_bram: both ports written in one cycle");

endmodule

//--- hw/llc_localmem.sv
`timescale 1ns/1ps
`include "llc_macros.svh"

module llc_localmem (
    input logic clk,
    input logic reset,
    llc_mem_if.mem mem
);

    localparam int NUM_BANKS = 1 << `LLC_BANK_BITS;
    localparam int NUM_PAIRS = `LLC_NUM_WAYS / 2;
    localparam int LOW_BITS = `LLC_SET_BITS - `LLC_BANK_BITS;
    // two ways per ram, selected by the top address bit
    localparam int DEPTH = 2 << LOW_BITS;

    typedef logic [`LLC_BANK_BITS-1:0] bank_t;

    logic [LOW_BITS-1:0] ram_set;
    bank_t wr_bank;
    bank_t rd_bank;
    bank_t rd_bank_q;

    llc_pkg::llc_meta_t meta_q [NUM_BANKS][`LLC_NUM_WAYS];
    llc_pkg::line_t line_q [NUM_BANKS][`LLC_NUM_WAYS];

    // one address per ram, writes and reads never overlap
    assign ram_set = mem.wr_en ? mem.wr_set[LOW_BITS-1:0] : mem.rd_set[LOW_BITS-1:0];
    assign wr_bank = mem.wr_set[`LLC_SET_BITS-1 -: `LLC_BANK_BITS];
    assign rd_bank = mem.rd_set[`LLC_SET_BITS-1 -: `LLC_BANK_BITS];

    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        localparam bank_t BANK = bank_t'(b);

        logic en;

        // only the addressed bank reads
        assign en = mem.rd_en && (rd_bank == BANK);

        for (genvar p = 0; p < NUM_PAIRS; p++) begin : g_pair
            // low way bit picks the port, high bit picks the pair
            localparam llc_pkg::llc_way_t WAY_A = llc_pkg::llc_way_t'(2 * p);
            localparam llc_pkg::llc_way_t WAY_B = llc_pkg::llc_way_t'(2 * p + 1);

            logic we_a;
            logic we_b;

            assign we_a = mem.wr_en && (wr_bank == BANK) && (mem.wr_way == WAY_A);
            assign we_b = mem.wr_en && (wr_bank == BANK) && (mem.wr_way == WAY_B);

            dp_bram #(
                .payload_t(llc_pkg::llc_meta_t),
                .DEPTH(DEPTH)
            ) u_meta_ram (
                .clk(clk),
                .addr_a({1'b0, ram_set}),
                .addr_b({1'b1, ram_set}),
                .we_a(we_a),
                .we_b(we_b),
                .en(en),
                .d(mem.wr_entry.meta),
                .q_a(meta_q[b][2*p]),
                .q_b(meta_q[b][2*p+1])
            );

            dp_bram #(
                .payload_t(llc_pkg::line_t),
                .DEPTH(DEPTH)
            ) u_line_ram (
                .clk(clk),
                .addr_a({1'b0, ram_set}),
                .addr_b({1'b1, ram_set}),
                .we_a(we_a),
                .we_b(we_b),
                .en(en),
                .d(mem.wr_entry.line),
                .q_a(line_q[b][2*p]),
                .q_b(line_q[b][2*p+1])
            );
        end
    end

    // bank of the data now leaving the rams
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_bank_q <= '0;
        end else if (mem.rd_en) begin
            rd_bank_q <= rd_bank;
        end
    end

    always_comb begin
        for (int w = 0; w < `LLC_NUM_WAYS; w++) begin
            mem.rd_entry[w] = {meta_q[rd_bank_q][w], line_q[rd_bank_q][w]};
        end
    end

    a_rd_wr_exclusive: assert property (
        @(posedge clk) disable iff (reset) !(mem.rd_en && mem.wr_en)
    ) else $error("llc_localmem: read and write requested together");

    a_wr_way_known: assert property (
        @(posedge clk) disable iff (reset) mem.wr_en |-> !$isunknown(mem.wr_way)
    ) else $error("llc_localmem: unknown way on write");

endmodule

//--- hw/llc_apb_access.sv
`timescale 1ns/1ps
`include "llc_macros.svh"

module llc_apb_access (
    input logic clk,
    input logic reset,
    input logic [7:0] paddr,
    input logic psel,
    input logic penable,
    input logic pwrite,
    input logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic pready,
    output logic pslverr,
    llc_mem_if.ctrl mem
);

    typedef enum logic [1:0] {
        st_idle,
        st_wait,
        st_capture
    } cmd_state_t;

    cmd_state_t state_q;

    llc_pkg::llc_set_t set_q;
    llc_pkg::llc_way_t way_q;
    llc_pkg::llc_entry_t stage_q;
    llc_pkg::llc_entry_t rb_q;
    logic rb_valid_q;

    logic access;
    logic reg_wr;
    logic cmd_hit;
    logic wr_cmd;
    logic rd_cmd;
    logic mapped;
    llc_pkg::llc_entry_t src;

    function automatic logic [31:0] meta_word(llc_pkg::llc_meta_t m);
        meta_word = {14'd0, m.evict_way, m.dirty, m.hprot, m.sharers, m.owner, m.state};
    endfunction

    assign access = psel && penable;
    assign reg_wr = access && pwrite && (state_q == st_idle);
    assign cmd_hit = reg_wr && (paddr == `LLC_REG_CMD);
    // write wins when both bits are set
    assign wr_cmd = cmd_hit && pwdata[0];
    assign rd_cmd = cmd_hit && !pwdata[0] && pwdata[1];

    assign mem.wr_en = wr_cmd;
    assign mem.wr_set = set_q;
    assign mem.wr_way = way_q;
    assign mem.wr_entry = stage_q;
    assign mem.rd_en = rd_cmd;
    assign mem.rd_set = set_q;

    // read command holds the bus for two extra cycles
    assign pready = access && ((state_q == st_capture) || (state_q == st_idle && !rd_cmd));
    assign pslverr = access && !mapped;

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= st_idle;
        end else begin
            case (state_q)
                st_idle: begin
                    if (rd_cmd) begin
                        state_q <= st_wait;
                    end
                end
                st_wait: state_q <= st_capture;
                default: state_q <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            set_q <= '0;
            way_q <= '0;
            stage_q <= '0;
            rb_q <= '0;
            rb_valid_q <= 1'b0;
        end else begin
            if (reg_wr) begin
                case (paddr)
                    `LLC_REG_SET: set_q <= pwdata[`LLC_SET_BITS-1:0];
                    `LLC_REG_WAY: way_q <= pwdata[$bits(llc_pkg::llc_way_t)-1:0];
                    `LLC_REG_TAG: stage_q.meta.tag <= pwdata[`LLC_TAG_BITS-1:0];
                    `LLC_REG_META: begin
                        stage_q.meta.state <= llc_pkg::llc_state_t'(pwdata[2:0]);
                        stage_q.meta.owner <= pwdata[5:3];
                        stage_q.meta.sharers <= pwdata[13:6];
                        stage_q.meta.hprot <= pwdata[14];
                        stage_q.meta.dirty <= pwdata[15];
                        stage_q.meta.evict_way <= pwdata[17:16];
                    end
                    `LLC_REG_LINE_LO: stage_q.line[31:0] <= pwdata;
                    `LLC_REG_LINE_HI: stage_q.line[`LLC_LINE_BITS-1:32] <= pwdata;
                    default: ;
                endcase
            end
            // rd_entry is valid while waiting
            if (state_q == st_wait) begin
                rb_q <= mem.rd_entry[way_q];
                rb_valid_q <= 1'b1;
            end
        end
    end

    // after the first read command, TAG/META/LINE show the captured entry
    assign src = rb_valid_q ? rb_q : stage_q;

    always_comb begin
        mapped = 1'b1;
        prdata = '0;
        case (paddr)
            `LLC_REG_SET: prdata = 32'(set_q);
            `LLC_REG_WAY: prdata = 32'(way_q);
            `LLC_REG_TAG: prdata = 32'(src.meta.tag);
            `LLC_REG_META: prdata = meta_word(src.meta);
            `LLC_REG_LINE_LO: prdata = src.line[31:0];
            `LLC_REG_LINE_HI: prdata = src.line[`LLC_LINE_BITS-1:32];
            `LLC_REG_CMD: prdata = '0;
            default: mapped = 1'b0;
        endcase
    end

    a_penable_needs_psel: assert property (
        @(posedge clk) disable iff (reset) penable |-> psel
    ) else $error("llc_apb_access: penable without psel");

endmodule

//--- hw/llc_mem_top.sv
`timescale 1ns/1ps

module llc_mem_top (
    input logic clk,
    input logic reset,
    input logic [7:0] paddr,
    input logic psel,
    input logic penable,
    input logic pwrite,
    input logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic pready,
    output logic pslverr
);

    llc_mem_if u_mem_if ();

    llc_apb_access u_apb_access (
        .clk(clk),
        .reset(reset),
        .paddr(paddr),
        .psel(psel),
        .penable(penable),
        .pwrite(pwrite),
        .pwdata(pwdata),
        .prdata(prdata),
        .pready(pready),
        .pslverr(pslverr),
        .mem(u_mem_if.ctrl)
    );

    // banked way-paired array
    llc_localmem u_localmem (
        .clk(clk),
        .reset(reset),
        .mem(u_mem_if.mem)
    );

endmodule

//--- verification/llc_mem_tb.sv
`timescale 1ns/1ps
`include "llc_macros.svh"

module llc_mem_tb;

    localparam int NUM_SETS = 1 << `LLC_SET_BITS;
    localparam int PREADY_TIMEOUT = 20;

    logic clk;
    logic reset;
    logic [7:0] paddr;
    logic psel;
    logic penable;
    logic pwrite;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic pready;
    logic pslverr;

    integer seed;

    // expected contents, kept in register layout
    logic [31:0] sb_tag [NUM_SETS][`LLC_NUM_WAYS];
    logic [31:0] sb_meta [NUM_SETS][`LLC_NUM_WAYS];
    logic [63:0] sb_line [NUM_SETS][`LLC_NUM_WAYS];

    llc_mem_top u_llc_mem_top (
        .clk(clk),
        .reset(reset),
        .paddr(paddr),
        .psel(psel),
        .penable(penable),
        .pwrite(pwrite),
        .pwdata(pwdata),
        .prdata(prdata),
        .pready(pready),
        .pslverr(pslverr)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else
            stop_with_failure($sformatf("[ERROR] %s got 0x%08h expected 0x%08h",
                                        name, got, exp));
    endtask

    // caller sits just past a rising edge
    task automatic apb_transfer(input logic wr, input logic [7:0] addr,
                                input logic [31:0] wdata, output logic [31:0] rdata,
                                output logic slverr, output int waits);
        paddr = addr;
        pwrite = wr;
        pwdata = wdata;
        psel = 1'b1;
        penable = 1'b0;
        @(posedge clk);
        #2;
        penable = 1'b1;
        waits = 0;
        #1;
        while (!pready) begin
            if (waits >= PREADY_TIMEOUT) begin
                stop_with_failure($sformatf("no pready after %0d cycles at offset 0x%02h",
                                            PREADY_TIMEOUT, addr));
            end
            @(posedge clk);
            #3;
            waits++;
        end
        rdata = prdata;
        slverr = pslverr;
        @(posedge clk);
        #2;
        psel = 1'b0;
        penable = 1'b0;
    endtask

    task automatic reg_write(input logic [7:0] addr, input logic [31:0] data,
                             input int exp_waits);
        logic [31:0] rd;
        logic err;
        int waits;
        apb_transfer(1'b1, addr, data, rd, err, waits);
        check_value($sformatf("pslverr write 0x%02h", addr), {31'd0, err}, 32'h0);
        check_value($sformatf("wait states write 0x%02h", addr), waits, exp_waits);
    endtask

    task automatic reg_read(input logic [7:0] addr, output logic [31:0] data);
        logic err;
        int waits;
        apb_transfer(1'b0, addr, 32'h0, data, err, waits);
        check_value($sformatf("pslverr read 0x%02h", addr), {31'd0, err}, 32'h0);
        check_value($sformatf("wait states read 0x%02h", addr), waits, 0);
    endtask

    task automatic write_entry(input int set, input int way, input logic [31:0] tag,
                               input logic [31:0] meta, input logic [63:0] line,
                               input logic [31:0] cmd);
        reg_write(`LLC_REG_SET, set, 0);
        reg_write(`LLC_REG_WAY, way, 0);
        reg_write(`LLC_REG_TAG, tag, 0);
        reg_write(`LLC_REG_META, meta, 0);
        reg_write(`LLC_REG_LINE_LO, line[31:0], 0);
        reg_write(`LLC_REG_LINE_HI, line[63:32], 0);
        // write command, no wait states
        reg_write(`LLC_REG_CMD, cmd, 0);
        sb_tag[set][way] = tag;
        sb_meta[set][way] = meta;
        sb_line[set][way] = line;
    endtask

    task automatic write_random_entry(input int set, input int way, input logic [31:0] cmd);
        int state;
        logic [31:0] tag;
        logic [31:0] meta;
        logic [63:0] line;
        tag = {16'd0, 16'($random(seed))};
        // legal states only, bits above evict_way stay zero
        state = $unsigned($random(seed)) % 5;
        meta = {14'd0, 18'($random(seed))};
        meta[2:0] = state[2:0];
        line = {$random(seed), $random(seed)};
        write_entry(set, way, tag, meta, line, cmd);
    endtask

    task automatic check_entry(input int set, input int way);
        logic [31:0] rd;
        reg_write(`LLC_REG_SET, set, 0);
        reg_write(`LLC_REG_WAY, way, 0);
        // read command stretched by two wait states
        reg_write(`LLC_REG_CMD, 32'h2, 2);
        reg_read(`LLC_REG_TAG, rd);
        check_value($sformatf("TAG set %0d way %0d", set, way), rd, sb_tag[set][way]);
        reg_read(`LLC_REG_META, rd);
        check_value($sformatf("META set %0d way %0d", set, way), rd, sb_meta[set][way]);
        reg_read(`LLC_REG_LINE_LO, rd);
        check_value($sformatf("LINE_LO set %0d way %0d", set, way), rd,
                    sb_line[set][way][31:0]);
        reg_read(`LLC_REG_LINE_HI, rd);
        check_value($sformatf("LINE_HI set %0d way %0d", set, way), rd,
                    sb_line[set][way][63:32]);
    endtask

    initial begin
        int sets [6];
        logic [31:0] rd;
        logic err;
        int waits;
        seed = 85442;
        reset = 1'b1;
        paddr = 8'h0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        pwdata = 32'h0;
        repeat (10) @(posedge clk);
        #2;
        reset = 1'b0;

        reg_read(`LLC_REG_TAG, rd);
        check_value("TAG after reset", rd, 32'h0);
        reg_read(`LLC_REG_META, rd);
        check_value("META after reset", rd, 32'h0);
        reg_read(`LLC_REG_LINE_LO, rd);
        check_value("LINE_LO after reset", rd, 32'h0);
        reg_read(`LLC_REG_LINE_HI, rd);
        check_value("LINE_HI after reset", rd, 32'h0);

        // 5 and 37 share ram addresses in different banks
        sets = '{5, 37, 20, 52, 0, 63};
        foreach (sets[i]) begin
            for (int w = 0; w < `LLC_NUM_WAYS; w++) begin
                write_random_entry(sets[i], w, 32'h1);
            end
        end
        foreach (sets[i]) begin
            for (int w = 0; w < `LLC_NUM_WAYS; w++) begin
                check_entry(sets[i], w);
            end
        end

        // overwrite one way, both command bits set
        write_random_entry(37, 2, 32'h3);
        for (int w = 0; w < `LLC_NUM_WAYS; w++) begin
            check_entry(37, w);
        end

        apb_transfer(1'b1, 8'h1C, 32'hFFFF_FFFF, rd, err, waits);
        check_value("pslverr unmapped write", {31'd0, err}, 32'h1);
        check_value("wait states unmapped write", waits, 0);
        apb_transfer(1'b0, 8'h40, 32'h0, rd, err, waits);
        check_value("pslverr unmapped read", {31'd0, err}, 32'h1);
        check_value("wait states unmapped read", waits, 0);
        foreach (sets[i]) begin
            for (int w = 0; w < `LLC_NUM_WAYS; w++) begin
                check_entry(sets[i], w);
            end
        end

        $display("Everything OK");
        $finish;
    end

endmodule

//--- compile.f
+incdir+hw
hw/llc_pkg.sv
hw/llc_mem_if.sv
hw/dp_bram.sv
hw/llc_localmem.sv
hw/llc_apb_access.sv
hw/llc_mem_top.sv
verification/llc_mem_tb.sv

//--- Makefile
TOP = llc_mem_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f compile.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f compile.f --top-module $(TOP)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "Everything OK"

clean:
	rm -rf obj_dir
